// File: testbench/uart_link_tests.txt
# name  byte_hex  bad_stop  back_to_back  reply_hex  enable_after  overrun
# First entry is the startup announce, its byte is never sent
announce     00 0 0 3C 0 0
on_first     33 0 0 3C 1 0
on_again     33 0 0 3C 1 0
off          66 0 0 3C 0 0
toggle_up    9D 0 0 3C 1 0
toggle_down  9D 0 0 3C 0 0
echo_a5      A5 0 0 A5 0 0
echo_00      00 0 0 00 0 0
echo_ff      FF 0 0 FF 0 0
echo_ack     3C 0 0 3C 0 0
echo_nak     C3 0 0 C3 0 0
on_mid       33 0 0 3C 1 0
echo_keep    5A 0 0 5A 1 0
nak_off      66 1 0 C3 1 0
nak_toggle   9D 1 0 C3 1 0
nak_echo     81 1 0 C3 1 0
bp_off       66 0 0 3C 0 0
bp_toggle    9D 0 1 3C 1 0
burst_off    66 0 0 3C 0 0
burst_on     33 0 1 3C 1 0
burst_toggle 9D 0 1 3C 0 0
last_echo    7E 0 0 7E 0 0

// File: build.f
+incdir+common
common/uart_link_pkg.sv
hdl/baud_timer.sv
uart/uart_rx.sv
uart/uart_tx.sv
hdl/link_ctrl.sv
hdl/uart_link_top.sv
testbench/tb_uart_link.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_uart_link
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/tb_uart_link.sv
/* UART link testbench */

`default_nettype none

`include "uart_link_params.svh"

module tb_uart_link;

    localparam int CLKS      = `UART_CLKS_PER_BIT;
    localparam int STARTUP   = `UART_STARTUP_CYCLES;
    localparam int MAX_TESTS = 64;

    logic clk;
    logic rst_n;
    logic rx;
    logic tx;
    logic ready;
    logic enable;
    logic overrun;

    // Test table with the startup announce at entry 0
    logic [127:0] t_name  [MAX_TESTS];
    logic [7:0]   t_byte  [MAX_TESTS];
    logic         t_bad   [MAX_TESTS];
    logic         t_b2b   [MAX_TESTS];
    logic [7:0]   t_reply [MAX_TESTS];
    logic         t_en    [MAX_TESTS];
    logic         t_ovr   [MAX_TESTS];
    int           n_tests;
    int           replies_done;
    int           cycles = 0;
    int           cycle_limit = 0;      // Zero until the table is read

    uart_link_top dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .rx      (rx),
        .tx      (tx),
        .ready   (ready),
        .enable  (enable),
        .overrun (overrun)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input logic [127:0] name, input string what,
                               input logic [7:0] exp, input logic [7:0] act);
        assert (act === exp)
        else stop_on_error($sformatf("ERROR %0s %s: expected %h, actual %h",
                                     name, what, exp, act));
    endtask

    // Run limit from the table length
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            stop_on_error($sformatf("Timeout, no progress after %0d cycles", cycles));
        end
    end

    task automatic read_tests();
        int           fd;
        int           n;
        string        line;
        logic [127:0] name;
        int           b;
        int           bad;
        int           b2b;
        int           rep;
        int           en;
        int           ovr;
        fd = $fopen("testbench/uart_link_tests.txt", "r");
        if (fd == 0) begin
            stop_on_error("Could not open testbench/uart_link_tests.txt");
        end else begin
            n_tests = 0;
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#" && n_tests < MAX_TESTS) begin
                    n = $sscanf(line, "%s %h %d %d %h %d %d",
                                name, b, bad, b2b, rep, en, ovr);
                    if (n == 7) begin
                        t_name[n_tests]  = name;
                        t_byte[n_tests]  = b[7:0];
                        t_bad[n_tests]   = bad[0];
                        t_b2b[n_tests]   = b2b[0];
                        t_reply[n_tests] = rep[7:0];
                        t_en[n_tests]    = en[0];
                        t_ovr[n_tests]   = ovr[0];
                        n_tests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Start, data LSB first, stop
    task automatic send_byte(input logic [7:0] data, input logic bad_stop);
        logic [9:0] frame;
        frame = {!bad_stop, data, 1'b0};
        @(posedge clk);
        for (int i = 0; i < 10; i++) begin
            rx <= frame[i];
            repeat (CLKS) @(posedge clk);
        end
        rx <= 1'b1;                     // Back to idle
    endtask

    // Deserialize one tx frame at mid-bit
    task automatic capture_frame(output logic [7:0] data, output logic en_start,
                                 output logic ovr_start, output logic rdy_start,
                                 output logic frame_ok);
        @(negedge clk);
        while (tx !== 1'b0) begin
            @(negedge clk);
        end
        en_start  = enable;             // Updated with tx_start
        ovr_start = overrun;
        rdy_start = ready;
        repeat (CLKS / 2) @(negedge clk);
        frame_ok = (tx === 1'b0);
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS) @(negedge clk);
            data[i] = tx;
        end
        repeat (CLKS) @(negedge clk);
        frame_ok = frame_ok && (tx === 1'b1);
    endtask

    task automatic check_reply(input int idx);
        logic [7:0] got;
        logic       en_s;
        logic       ovr_s;
        logic       rdy_s;
        logic       frm_ok;
        capture_frame(got, en_s, ovr_s, rdy_s, frm_ok);
        assert (frm_ok)
        else stop_on_error($sformatf("Bad start or stop bit on reply of %0s", t_name[idx]));
        assert (rdy_s === 1'b1)
        else stop_on_error($sformatf("ready is low when the reply of %0s starts", t_name[idx]));
        check_value(t_name[idx], "reply", t_reply[idx], got);
        check_value(t_name[idx], "enable", {7'd0, t_en[idx]}, {7'd0, en_s});
        check_value(t_name[idx], "overrun", {7'd0, t_ovr[idx]}, {7'd0, ovr_s});
        replies_done++;
    endtask

    task automatic drive_tests();
        for (int i = 1; i < n_tests; i++) begin
            if (!t_b2b[i]) begin
                wait (replies_done >= i);   // Previous reply fully seen
                repeat ($urandom_range(20, 1)) @(posedge clk);
            end
            send_byte(t_byte[i], t_bad[i]);
        end
    endtask

    task automatic check_replies();
        for (int i = 1; i < n_tests; i++) begin
            check_reply(i);
        end
    endtask

    initial begin : main
        void'($urandom(82));
        rst_n = 1'b0;
        rx    = 1'b1;
        replies_done = 0;
        read_tests();
        cycle_limit = STARTUP + (n_tests + 1) * 25 * CLKS;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        assert (tx === 1'b1) else stop_on_error("tx is not idle high after reset");
        assert (ready === 1'b0) else stop_on_error("ready is high right after reset");
        assert (enable === 1'b0) else stop_on_error("enable is high right after reset");

        // Announce frame
        check_reply(0);

        fork
            drive_tests();
            check_replies();
        join

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/uart_link_top.sv
/* UART command link top */

`default_nettype none

module uart_link_top (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic rx,           // Serial in, idle high
    output logic      tx,           // Serial out, idle high
    output logic      ready,
    output logic      enable,
    output logic      overrun
);

    import uart_link_pkg::*;

    byte_t rx_data;
    logic  rx_valid;
    logic  rx_frame_err;
    byte_t tx_data;
    logic  tx_start;
    logic  tx_busy;

    // Serial in
    uart_rx u_rx (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx           (rx),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_frame_err (rx_frame_err)
    );

    // Decode, queue and enable
    link_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_frame_err (rx_frame_err),
        .tx_busy      (tx_busy),
        .tx_data      (tx_data),
        .tx_start     (tx_start),
        .ready        (ready),
        .enable       (enable),
        .overrun      (overrun)
    );

    // Serial out
    uart_tx u_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

endmodule

`default_nettype wire

// File: hdl/link_ctrl.sv
/* Command link controller */

`default_nettype none

`include "uart_link_params.svh"

module link_ctrl (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire uart_link_pkg::byte_t rx_data,
    input  wire logic                 rx_valid,
    input  wire logic                 rx_frame_err,
    input  wire logic                 tx_busy,
    output uart_link_pkg::byte_t      tx_data,
    output logic                      tx_start,
    output logic                      ready,      // Announce has gone out
    output logic                      enable,     // Commanded level
    output logic                      overrun     // Sticky, byte lost
);

    import uart_link_pkg::*;

    localparam int unsigned STARTUP = `UART_STARTUP_CYCLES;
    localparam int unsigned CNT_W   = $clog2(STARTUP);

    // Enable effect of a command
    typedef enum logic [1:0] {
        ACT_KEEP,
        ACT_SET,
        ACT_CLEAR,
        ACT_INVERT
    } act_t;

    ctrl_state_t      state_q;
    logic [CNT_W-1:0] pwr_cnt_q;    // Power-up delay count
    logic             start_q;
    logic             ready_q;
    logic             enable_q;
    logic             overrun_q;
    logic             pend_q;       // Reply waiting for the line
    byte_t            pend_byte_q;
    act_t             pend_act_q;
    byte_t            tx_data_q;
    byte_t            dec_byte;     // Decoded reply
    act_t             dec_act;
    logic             byte_in;
    logic             tx_free;
    logic             issue;

    // Decode the incoming byte
    always_comb begin
        dec_byte = rx_data;                     // Echo unknown bytes
        dec_act  = ACT_KEEP;
        if (rx_frame_err) begin
            dec_byte = `LINK_NAK;
        end else begin
            case (rx_data)
                `LINK_CMD_ON: begin
                    dec_byte = `LINK_ACK;
                    dec_act  = ACT_SET;
                end
                `LINK_CMD_OFF: begin
                    dec_byte = `LINK_ACK;
                    dec_act  = ACT_CLEAR;
                end
                `LINK_CMD_TOGGLE: begin
                    dec_byte = `LINK_ACK;
                    dec_act  = ACT_INVERT;
                end
                default: ;
            endcase
        end
    end

    assign byte_in = ready_q && (rx_valid || rx_frame_err);     // Ignored before ready
    assign tx_free = !tx_busy && !start_q;      // Busy lags start by a cycle
    assign issue   = pend_q && tx_free &&
                     (state_q == ST_IDLE || state_q == ST_REPLY_WAIT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= ST_POWERUP;
            pwr_cnt_q <= '0;
            start_q   <= 1'b0;
            ready_q   <= 1'b0;
            enable_q  <= 1'b0;
            overrun_q <= 1'b0;
            pend_q    <= 1'b0;
        end else begin
            start_q <= 1'b0;
            case (state_q)
                ST_POWERUP: begin
                    pwr_cnt_q <= pwr_cnt_q + 1'b1;
                    if (pwr_cnt_q == CNT_W'(STARTUP - 1)) begin
                        state_q <= ST_ANNOUNCE;
                    end
                end
                ST_ANNOUNCE: begin
                    if (tx_free) begin
                        start_q <= 1'b1;
                        ready_q <= 1'b1;
                        state_q <= ST_REPLY_WAIT;
                    end
                end
                ST_IDLE: begin
                    if (issue) begin
                        start_q <= 1'b1;
                        state_q <= ST_REPLY_WAIT;
                    end
                end
                ST_REPLY_WAIT: begin
                    if (issue) begin
                        start_q <= 1'b1;          // Queued reply right behind
                    end else if (tx_free) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_POWERUP;
            endcase

            // Enable changes with its reply
            if (issue) begin
                case (pend_act_q)
                    ACT_SET:    enable_q <= 1'b1;
                    ACT_CLEAR:  enable_q <= 1'b0;
                    ACT_INVERT: enable_q <= !enable_q;
                    default:    ;
                endcase
            end

            // One deep queue
            if (byte_in) begin
                if (pend_q && !issue) begin
                    overrun_q <= 1'b1;            // No room, byte dropped
                end else begin
                    pend_q <= 1'b1;
                end
            end else if (issue) begin
                pend_q <= 1'b0;
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (byte_in && (!pend_q || issue)) begin
            pend_byte_q <= dec_byte;
            pend_act_q  <= dec_act;
        end
        if (state_q == ST_ANNOUNCE && tx_free) begin
            tx_data_q <= `LINK_ACK;
        end else if (issue) begin
            tx_data_q <= pend_byte_q;
        end
    end

    assign tx_data  = tx_data_q;
    assign tx_start = start_q;
    assign ready    = ready_q;
    assign enable   = enable_q;
    assign overrun  = overrun_q;

endmodule

`default_nettype wire

// File: uart/uart_tx.sv
/* UART transmitter */

`default_nettype none

module uart_tx (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire uart_link_pkg::byte_t tx_data,
    input  wire logic                 tx_start,   // One cycle pulse while idle
    output logic                      tx,         // Serial out idling high
    output logic                      tx_busy
);

    logic [9:0] frame_load;     // Stop, data, start
    logic [9:0] shift_q;        // Frame bits with the current bit at [0]
    logic [9:0] shift_nxt;
    logic [3:0] bit_cnt_q;      // Bits already on the line
    logic       tx_q;
    logic       busy_q;
    logic       load;
    logic       tick;

    assign frame_load = {1'b1, tx_data, 1'b0};
    assign shift_nxt  = {1'b1, shift_q[9:1]};     // Refill with idle level
    assign load       = tx_start;

    baud_timer u_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (busy_q),
        .restart    (load),
        .half_start (1'b0),             // Full periods only
        .tick       (tick)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_q      <= 1'b1;
            busy_q    <= 1'b0;
            bit_cnt_q <= '0;
        end else if (load) begin
            tx_q      <= frame_load[0];   // Start bit on next cycle
            busy_q    <= 1'b1;
            bit_cnt_q <= '0;
        end else if (busy_q && tick) begin
            if (bit_cnt_q == 4'd9) begin
                tx_q   <= 1'b1;           // Stop bit done
                busy_q <= 1'b0;
            end else begin
                tx_q      <= shift_nxt[0];
                bit_cnt_q <= bit_cnt_q + 1'b1;
            end
        end
    end

    // Frame shifter
    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= frame_load;
        end else if (busy_q && tick) begin
            shift_q <= shift_nxt;
        end
    end

    assign tx      = tx_q;              // Line driven from a flop
    assign tx_busy = busy_q;

endmodule

`default_nettype wire

// File: uart/uart_rx.sv
/* UART receiver */

`default_nettype none

module uart_rx (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            rx,            // Serial in, idle high
    output uart_link_pkg::byte_t rx_data,
    output logic                 rx_valid,      // Good byte
    output logic                 rx_frame_err   // Stop bit was low
);

    import uart_link_pkg::*;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t  state_q;
    logic       rx_meta_q;      // First sync stage
    logic       rx_sync_q;      // Second sync stage
    logic       rx_prev_q;      // For edge detect
    logic [2:0] bit_cnt_q;      // Data bit index
    byte_t      shift_q;        // Assembled byte, LSB first
    logic       valid_q;
    logic       ferr_q;
    logic       start_edge;
    logic       tick;

    // Line falls while idle
    assign start_edge = (state_q == RX_IDLE) && rx_prev_q && !rx_sync_q;

    baud_timer u_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (state_q != RX_IDLE),
        .restart    (start_edge),
        .half_start (1'b1),             // Land ticks at mid-bit
        .tick       (tick)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta_q <= 1'b1;
            rx_sync_q <= 1'b1;
            rx_prev_q <= 1'b1;
        end else begin
            rx_meta_q <= rx;
            rx_sync_q <= rx_meta_q;
            rx_prev_q <= rx_sync_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= RX_IDLE;
            bit_cnt_q <= '0;
            valid_q   <= 1'b0;
            ferr_q    <= 1'b0;
        end else begin
            valid_q <= 1'b0;            // Pulses by default
            ferr_q  <= 1'b0;
            case (state_q)
                RX_IDLE: begin
                    if (start_edge) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    if (tick) begin
                        // Still low at mid-bit, else a glitch
                        state_q   <= rx_sync_q ? RX_IDLE : RX_DATA;
                        bit_cnt_q <= '0;
                    end
                end
                RX_DATA: begin
                    if (tick) begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == 3'd7) begin
                            state_q <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (tick) begin
                        valid_q <= rx_sync_q;
                        ferr_q  <= !rx_sync_q;
                        state_q <= RX_IDLE;
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // Data path, no reset needed
    always_ff @(posedge clk) begin
        if (state_q == RX_DATA && tick) begin
            shift_q <= {rx_sync_q, shift_q[7:1]};
        end
    end

    assign rx_data      = shift_q;      // Stable while a pulse is out
    assign rx_valid     = valid_q;
    assign rx_frame_err = ferr_q;

endmodule

`default_nettype wire

// File: hdl/baud_timer.sv
/* Bit period timer */

`default_nettype none

`include "uart_link_params.svh"

module baud_timer #(
    parameter int unsigned CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic run,          // Count enable
    input  wire logic restart,      // Reload from the start of a period
    input  wire logic half_start,   // First period is half length
    output logic      tick          // End of bit period
);

    localparam int unsigned CNT_W = (CLKS_PER_BIT > 2) ? $clog2(CLKS_PER_BIT) : 1;
    localparam int unsigned HALF  = CLKS_PER_BIT / 2;

    localparam logic [CNT_W-1:0] LOAD_FULL = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] LOAD_HALF = CNT_W'(HALF - 1);

    logic [CNT_W-1:0] cnt_q;        // Cycles left in this period

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= LOAD_FULL;
        end else if (restart) begin
            cnt_q <= half_start ? LOAD_HALF : LOAD_FULL;
        end else if (run) begin
            if (cnt_q == '0) begin
                cnt_q <= LOAD_FULL;         // Back to back periods
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // One cycle pulse on the last cycle of a period
    assign tick = run && (cnt_q == '0);

endmodule

`default_nettype wire

// File: common/uart_link_pkg.sv
/* UART link shared types */

`default_nettype none

package uart_link_pkg;

    // One serial payload byte
    typedef logic [7:0] byte_t;

    // Controller states
    typedef enum logic [2:0] {
        ST_POWERUP    = 3'd0,  // Waiting out power-up delay
        ST_ANNOUNCE   = 3'd1,  // Sending the startup acknowledge
        ST_IDLE       = 3'd2,  // Transmitter free, nothing in flight
        ST_REPLY_WAIT = 3'd3   // Reply on the line
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: common/uart_link_params.svh
/* UART link timing and codes */

`ifndef UART_LINK_PARAMS_SVH
`define UART_LINK_PARAMS_SVH

// Serial bit timing
`define UART_CLKS_PER_BIT 8             // Clocks per bit, simulation value

// Power-up delay before the announce byte
`define UART_STARTUP_CYCLES 64

// Command codes received on rx
`define LINK_CMD_ON     8'h33           // Set enable
`define LINK_CMD_OFF    8'h66           // Clear enable
`define LINK_CMD_TOGGLE 8'h9D           // Invert enable

// Reply codes sent on tx
`define LINK_ACK 8'h3C                  // Command taken, also startup announce
`define LINK_NAK 8'hC3                  // Bad stop bit

`endif
